// ==== design/uart_pkg.sv ====
// ------------------------------------------------
// Shared UART constants: widths, register map,
// reset defaults, bit positions and IIR codes
// ------------------------------------------------

package uart_pkg;

  // ------------------------------------------------
  // Widths
  // ------------------------------------------------
  localparam int DATA_W     = 8;              // One register byte
  localparam int DIV_W      = 16;             // Divisor latch {DLH, DLL}
  localparam int OVERSAMPLE = 8;              // Receiver ticks per bit
  localparam int BIT_CNT_W  = 3;              // Counts 8 data bits

  // ------------------------------------------------
  // Register addresses {wb_adr_i, wb_sel_i[1]}
  // ------------------------------------------------
  localparam logic [2:0] REG_THR_RBR = 3'd0;  // THR/RBR, DLL with DLAB
  localparam logic [2:0] REG_IER     = 3'd1;  // IER, DLH with DLAB
  localparam logic [2:0] REG_IIR     = 3'd2;  // Read only
  localparam logic [2:0] REG_LCR     = 3'd3;  // Line control
  localparam logic [2:0] REG_LSR     = 3'd5;  // Line status

  // Reset values
  localparam logic [7:0] DLL_DEF = 8'h60;     // Divisor low
  localparam logic [7:0] DLH_DEF = 8'h00;     // Divisor high
  localparam logic [7:0] IER_DEF = 8'h00;     // All interrupts off
  localparam logic [7:0] LCR_DEF = 8'h03;     // 8 data bits

  // ------------------------------------------------
  // Bit positions
  // ------------------------------------------------
  localparam int LCR_DLAB  = 7;               // Divisor latch access
  localparam int IER_ERBI  = 0;               // Data available enable
  localparam int IER_ETBEI = 1;               // THR empty enable
  localparam int LSR_DR    = 0;               // Data ready
  localparam int LSR_OE    = 1;               // Overrun
  localparam int LSR_THRE  = 5;               // Holding register empty
  localparam int LSR_TEMT  = 6;               // Transmitter empty

  // Interrupt identification, bit 0 low means pending
  localparam logic [7:0] IIR_NONE = 8'h01;    // Nothing pending
  localparam logic [7:0] IIR_RDA  = 8'h04;    // Received data available
  localparam logic [7:0] IIR_THRE = 8'h02;    // Holding register empty

endpackage

// ==== design/uart_baud_timer.sv ====
// ------------------------------------------------
// Baud timer: integer divisor counter giving the
// 8x oversample tick and the bit tick
// ------------------------------------------------
`timescale 1ns/1ps

module uart_baud_timer import uart_pkg::*; (
  input  logic             wb_clk_i,              // System clock
  input  logic             wb_rst_i,              // Async reset, active high
  input  logic [DIV_W-1:0] divisor_i,             // {DLH, DLL}
  output logic             tick8_o,               // Oversample tick
  output logic             tick1_o                // Bit tick
);

  logic [DIV_W-1:0]              div_cnt;         // Down-counter
  logic [DIV_W-1:0]              div_q;           // Last divisor seen
  logic [$clog2(OVERSAMPLE)-1:0] sub_cnt;         // tick8 pulses in this bit

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      div_cnt <= '0;
      div_q   <= '0;
      sub_cnt <= '0;
      tick8_o <= 1'b0;
      tick1_o <= 1'b0;
    end else begin
      div_q   <= divisor_i;                       // Track for change detect
      tick8_o <= 1'b0;
      tick1_o <= 1'b0;
      if ((divisor_i != div_q) || (divisor_i == '0)) begin
        div_cnt <= divisor_i - 1'b1;              // Restart, or hold when zero
        sub_cnt <= '0;
      end else if (div_cnt == '0) begin
        div_cnt <= divisor_i - 1'b1;              // Reload
        tick8_o <= 1'b1;
        sub_cnt <= sub_cnt + 1'b1;                // Wraps after OVERSAMPLE
        if (sub_cnt == $bits(sub_cnt)'(OVERSAMPLE - 1))
          tick1_o <= 1'b1;                        // Every eighth tick8
      end else begin
        div_cnt <= div_cnt - 1'b1;
      end
    end
  end

  // Bit ticks are at least one bit time of tick8 pulses apart
  a_tick1_spacing: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    tick1_o |=> !tick1_o [*OVERSAMPLE-1]);

endmodule

// ==== design/uart_tx_fsm.sv ====
// ------------------------------------------------
// Transmitter: FSM that serializes one 8N1 frame
// on bit ticks
// ------------------------------------------------
`timescale 1ns/1ps

module uart_tx_fsm import uart_pkg::*; (
  input  logic              wb_clk_i,             // System clock
  input  logic              wb_rst_i,             // Async reset, active high
  input  logic              tick1_i,              // Bit tick
  input  logic              tx_start_i,           // Start pulse from THR write
  input  logic [DATA_W-1:0] tx_data_i,            // Byte to send
  output logic              tx_busy_o,            // Frame in progress
  output logic              rs232_tx_o            // Serial line
);

  localparam logic [2:0] S_IDLE  = 3'd0;          // Line idle high
  localparam logic [2:0] S_WAIT  = 3'd1;          // Align to next bit tick
  localparam logic [2:0] S_START = 3'd2;          // Start bit on line
  localparam logic [2:0] S_DATA  = 3'd3;          // Data bits, LSB first
  localparam logic [2:0] S_STOP  = 3'd4;          // Stop bit on line

  logic [2:0]           state;
  logic [DATA_W-1:0]    shift_q;                  // Outgoing byte
  logic [BIT_CNT_W-1:0] bit_cnt;                  // Data bit index

  assign tx_busy_o = (state != S_IDLE);

  // ------------------------------------------------
  // Frame sequencer
  // ------------------------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state      <= S_IDLE;
      bit_cnt    <= '0;
      rs232_tx_o <= 1'b1;                         // Mark
    end else begin
      case (state)
        S_IDLE: if (tx_start_i) state <= S_WAIT;  // Start ignored when busy
        S_WAIT: if (tick1_i) begin
          rs232_tx_o <= 1'b0;                     // Start bit
          state      <= S_START;
        end
        S_START: if (tick1_i) begin
          rs232_tx_o <= shift_q[0];               // Bit 0
          bit_cnt    <= '0;
          state      <= S_DATA;
        end
        S_DATA: if (tick1_i) begin
          if (bit_cnt == BIT_CNT_W'(DATA_W - 1)) begin
            rs232_tx_o <= 1'b1;                   // Stop bit
            state      <= S_STOP;
          end else begin
            rs232_tx_o <= shift_q[0];             // Next bit
            bit_cnt    <= bit_cnt + 1'b1;
          end
        end
        S_STOP: if (tick1_i) state <= S_IDLE;     // Busy falls here
        default: state <= S_IDLE;
      endcase
    end
  end

  // Byte latch and shifter
  always_ff @(posedge wb_clk_i) begin
    if ((state == S_IDLE) && tx_start_i)
      shift_q <= tx_data_i;                       // Latch on start
    else if (tick1_i && ((state == S_START) || (state == S_DATA)))
      shift_q <= shift_q >> 1;                    // Bit moved to line
  end

  a_idle_mark: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (state == S_IDLE) |-> rs232_tx_o);

endmodule

// ==== design/uart_rx.sv ====
// ------------------------------------------------
// Receiver: input synchronizer, 8x oversampled
// start detect, mid-bit sampling, stop check
// ------------------------------------------------
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
  input  logic              wb_clk_i,             // System clock
  input  logic              wb_rst_i,             // Async reset, active high
  input  logic              tick8_i,              // Oversample tick
  input  logic              rs232_rx_i,           // Serial line, async
  output logic              rx_valid_o,           // Byte received pulse
  output logic [DATA_W-1:0] rx_data_o             // Received byte
);

  localparam logic [1:0] S_HUNT  = 2'd0;          // Wait for low
  localparam logic [1:0] S_START = 2'd1;          // Confirm start at mid-bit
  localparam logic [1:0] S_DATA  = 2'd2;          // Sample 8 bits
  localparam logic [1:0] S_STOP  = 2'd3;          // Check stop bit

  logic                          rx_s1;           // Sync stage 1
  logic                          rx_s2;           // Sync stage 2
  logic [1:0]                    state;
  logic [$clog2(OVERSAMPLE)-1:0] smp_cnt;         // Ticks within a bit
  logic [BIT_CNT_W-1:0]          bit_cnt;         // Data bit index
  logic [DATA_W-1:0]             shift_q;         // Incoming byte
  logic                          mid_bit;         // One bit time since last sample

  assign mid_bit = tick8_i && (smp_cnt == $bits(smp_cnt)'(OVERSAMPLE - 1));

  // ------------------------------------------------
  // Synchronizer and sequencer
  // ------------------------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      rx_s1      <= 1'b1;
      rx_s2      <= 1'b1;
      state      <= S_HUNT;
      smp_cnt    <= '0;
      bit_cnt    <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_s1      <= rs232_rx_i;
      rx_s2      <= rx_s1;
      rx_valid_o <= 1'b0;
      if (tick8_i && (state != S_HUNT))
        smp_cnt <= smp_cnt + 1'b1;                // Wraps each bit time
      case (state)
        S_HUNT: if (tick8_i && !rx_s2) begin
          smp_cnt <= '0;                          // First low sample
          state   <= S_START;
        end
        // Third tick after detection lands near the start bit middle
        S_START: if (tick8_i && (smp_cnt == $bits(smp_cnt)'(OVERSAMPLE / 2 - 2))) begin
          smp_cnt <= '0;
          bit_cnt <= '0;
          state   <= rx_s2 ? S_HUNT : S_DATA;     // Glitch goes back to hunt
        end
        S_DATA: if (mid_bit) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == BIT_CNT_W'(DATA_W - 1))
            state <= S_STOP;
        end
        S_STOP: if (mid_bit) begin
          rx_valid_o <= rx_s2;                    // Bad stop drops the frame
          state      <= S_HUNT;
        end
        default: state <= S_HUNT;
      endcase
    end
  end

  // Data path, LSB arrives first
  always_ff @(posedge wb_clk_i) begin
    if ((state == S_DATA) && mid_bit)
      shift_q <= {rx_s2, shift_q[DATA_W-1:1]};
    if ((state == S_STOP) && mid_bit && rx_s2)
      rx_data_o <= shift_q;                       // Hold for register file
  end

  a_valid_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    rx_valid_o |=> !rx_valid_o);

endmodule

// ==== design/uart_regs.sv ====
// ------------------------------------------------
// 8250 style register file: lane steering, ack,
// divisor latch, IER/LCR/IIR/LSR and interrupts
// ------------------------------------------------
`timescale 1ns/1ps

module uart_regs import uart_pkg::*; (
  input  logic                wb_clk_i,           // System clock
  input  logic                wb_rst_i,           // Async reset, active high
  input  logic [2*DATA_W-1:0] wb_dat_i,           // Write data, two lanes
  output logic [2*DATA_W-1:0] wb_dat_o,           // Read data, two lanes
  input  logic                wb_cyc_i,           // Cycle
  input  logic                wb_stb_i,           // Strobe
  input  logic [1:0]          wb_adr_i,           // Word address
  input  logic [1:0]          wb_sel_i,           // Lane select
  input  logic                wb_we_i,            // Write enable
  output logic                wb_ack_o,           // Registered ack
  output logic                wb_tgc_o,           // Interrupt request
  input  logic                rx_valid_i,         // Byte from receiver
  input  logic [DATA_W-1:0]   rx_data_i,
  input  logic                tx_busy_i,          // Transmitter level
  output logic                tx_start_o,         // Send pulse
  output logic [DATA_W-1:0]   tx_data_o,          // THR contents
  output logic [DIV_W-1:0]    divisor_o           // To baud timer
);

  logic [2:0]        reg_adr;                     // 8250 register index
  logic [DATA_W-1:0] dat_i;                       // Byte from selected lane
  logic [DATA_W-1:0] dat_q;                       // Read data latch
  logic              acc, wr, rd;                 // Access acts once
  logic [DATA_W-1:0] dll, dlh, lcr, rbr;
  logic [1:0]        ier;                         // ETBEI, ERBI
  logic              dr, oe, thre, thre_q, thre_int, busy_q;
  logic              dlab, rda_act, thre_act;
  logic [DATA_W-1:0] iir_val, lsr_val, rd_mux;

  // ------------------------------------------------
  // Bus decode
  // ------------------------------------------------
  assign reg_adr  = {wb_adr_i, wb_sel_i[1]};
  assign dat_i    = wb_sel_i[0] ? wb_dat_i[DATA_W-1:0] : wb_dat_i[2*DATA_W-1:DATA_W];
  assign wb_dat_o = wb_sel_i[0] ? {{DATA_W{1'b0}}, dat_q} : {dat_q, {DATA_W{1'b0}}};
  assign acc      = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr       = acc & wb_we_i;
  assign rd       = acc & ~wb_we_i;

  assign dlab      = lcr[LCR_DLAB];
  assign divisor_o = {dlh, dll};
  assign rda_act   = dr & ier[IER_ERBI];
  assign thre_act  = thre_int & ier[IER_ETBEI];
  assign wb_tgc_o  = rda_act | thre_act;

  // Data available outranks THR empty
  assign iir_val = rda_act ? IIR_RDA : (thre_act ? IIR_THRE : IIR_NONE);

  always_comb begin
    lsr_val           = '0;
    lsr_val[LSR_DR]   = dr;
    lsr_val[LSR_OE]   = oe;
    lsr_val[LSR_THRE] = thre;
    lsr_val[LSR_TEMT] = thre & ~tx_busy_i;        // Shift register idle too
    case (reg_adr)
      REG_THR_RBR: rd_mux = dlab ? dll : rbr;
      REG_IER:     rd_mux = dlab ? dlh : {{(DATA_W-2){1'b0}}, ier};
      REG_IIR:     rd_mux = iir_val;
      REG_LCR:     rd_mux = lcr;
      REG_LSR:     rd_mux = lsr_val;
      default:     rd_mux = '0;                   // Dropped registers
    endcase
  end

  // ------------------------------------------------
  // Control registers and flags
  // ------------------------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wb_ack_o   <= 1'b0;
      tx_start_o <= 1'b0;
      dll        <= DLL_DEF;
      dlh        <= DLH_DEF;
      ier        <= IER_DEF[1:0];
      lcr        <= LCR_DEF;
      dr         <= 1'b0;
      oe         <= 1'b0;
      thre       <= 1'b1;                         // Empty after reset
      thre_q     <= 1'b1;
      thre_int   <= 1'b0;
      busy_q     <= 1'b0;
    end else begin
      wb_ack_o   <= acc;                          // One cycle, then gap
      tx_start_o <= wr && (reg_adr == REG_THR_RBR) && !dlab;
      busy_q     <= tx_busy_i;
      thre_q     <= thre;
      if (wr) begin
        case (reg_adr)
          REG_THR_RBR: if (dlab) dll <= dat_i;
          REG_IER:     if (dlab) dlh <= dat_i; else ier <= dat_i[1:0];
          REG_LCR:     lcr <= dat_i;
          default:     ;                          // Read only or absent
        endcase
      end
      if (busy_q && !tx_busy_i) thre <= 1'b1;     // Frame finished
      else if (wr && (reg_adr == REG_THR_RBR) && !dlab) thre <= 1'b0;
      if (rd && (reg_adr == REG_THR_RBR) && !dlab) dr <= 1'b0;
      if (rd && (reg_adr == REG_LSR)) oe <= 1'b0;
      if (rx_valid_i) begin
        dr <= 1'b1;                               // Arrival beats clear
        if (dr) oe <= 1'b1;                       // Unread byte lost
      end
      if ((rd && (reg_adr == REG_IIR) && (iir_val == IIR_THRE)) ||
          (wr && (reg_adr == REG_THR_RBR) && !dlab))
        thre_int <= 1'b0;
      else if (thre && !thre_q && ier[IER_ETBEI])
        thre_int <= 1'b1;                         // Rising THRE latched
    end
  end

  // Payload registers
  always_ff @(posedge wb_clk_i) begin
    if (rd) dat_q <= rd_mux;                      // Valid with ack
    if (wr && (reg_adr == REG_THR_RBR) && !dlab) tx_data_o <= dat_i;
    if (rx_valid_i) rbr <= rx_data_i;             // Overwrites on overrun
  end

  a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

// ==== design/uart_top.sv ====
// ------------------------------------------------
// UART top: register file, baud timer, transmitter
// and receiver
// ------------------------------------------------
`timescale 1ns/1ps

module uart_top import uart_pkg::*; (
  input  logic                wb_clk_i,           // System clock
  input  logic                wb_rst_i,           // Async reset, active high
  input  logic [2*DATA_W-1:0] wb_dat_i,
  output logic [2*DATA_W-1:0] wb_dat_o,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic [1:0]          wb_adr_i,
  input  logic [1:0]          wb_sel_i,
  input  logic                wb_we_i,
  output logic                wb_ack_o,
  output logic                wb_tgc_o,           // Interrupt
  input  logic                rs232_rx_i,         // Serial in
  output logic                rs232_tx_o          // Serial out
);

  logic              tick8, tick1;                // Baud ticks
  logic              tx_start, tx_busy, rx_valid;
  logic [DATA_W-1:0] tx_data, rx_data;
  logic [DIV_W-1:0]  divisor;

  uart_regs u_regs (
    .wb_clk_i, .wb_rst_i, .wb_dat_i, .wb_dat_o, .wb_cyc_i, .wb_stb_i,
    .wb_adr_i, .wb_sel_i, .wb_we_i, .wb_ack_o, .wb_tgc_o,
    .rx_valid_i(rx_valid), .rx_data_i(rx_data), .tx_busy_i(tx_busy),
    .tx_start_o(tx_start), .tx_data_o(tx_data), .divisor_o(divisor)
  );

  uart_baud_timer u_baud (.wb_clk_i, .wb_rst_i, .divisor_i(divisor),
    .tick8_o(tick8), .tick1_o(tick1));

  uart_tx_fsm u_tx (.wb_clk_i, .wb_rst_i, .tick1_i(tick1), .tx_start_i(tx_start),
    .tx_data_i(tx_data), .tx_busy_o(tx_busy), .rs232_tx_o);

  uart_rx u_rx (.wb_clk_i, .wb_rst_i, .tick8_i(tick8), .rs232_rx_i,
    .rx_valid_o(rx_valid), .rx_data_o(rx_data));

endmodule

// ==== testbench/uart_tb.sv ====
// ------------------------------------------------
// uart_top testbench: access table, serial driver
// and monitor, LFSR bytes, cycle watchdog
// ------------------------------------------------
`timescale 1ns/1ps

module uart_tb import uart_pkg::*; ();

  localparam int BIT_CYC = 16;                    // 8 x divisor 2
  localparam logic [2:0] OP_WR = 3'd0, OP_RD = 3'd1, OP_SEND = 3'd2;
  localparam logic [2:0] OP_TX = 3'd3, OP_IRQ = 3'd4;

  typedef struct packed {
    logic [2:0] op;                               // Operation
    logic [2:0] adr;                              // 8250 register index
    logic       lo;                               // Low lane when set
    logic [7:0] data;                             // Write or serial byte
    logic [7:0] exp;                              // Expected byte or level
  } step_t;

  logic        wb_clk_i = 1'b0;
  logic        wb_rst_i, wb_cyc_i, wb_stb_i, wb_we_i, rs232_rx_i;
  logic [1:0]  wb_adr_i, wb_sel_i;
  logic [15:0] wb_dat_i, wb_dat_o;
  logic        wb_ack_o, wb_tgc_o, rs232_tx_o;
  step_t       steps[$];                          // Access table
  int          errors = 0;
  int          cycle_cnt = 0;
  int          cost_sum = 0;                      // Nominal cycles of all steps
  int          cycle_limit = 32'h7fff_ffff;
  logic [31:0] lfsr = 32'hb3c0;

  uart_top dut0 (.*);

  always #4 wb_clk_i = ~wb_clk_i;                 // 8 ns period

  // ------------------------------------------------
  // Watchdog
  // ------------------------------------------------
  always @(posedge wb_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: run passed %0d cycles, errors %0d", cycle_limit, errors);
      $display("Test failed");
      $finish;
    end
  end

  // Galois LFSR, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      b[i] = lfsr[0];                             // One step per bit
    end
    return b;
  endfunction

  task automatic add_step(input logic [2:0] op, input logic [2:0] adr, input logic lo,
                          input logic [7:0] data, input logic [7:0] exp);
    steps.push_back({op, adr, lo, data, exp});
    case (op)
      OP_SEND: cost_sum += 10 * BIT_CYC;          // Whole frame
      OP_TX:   cost_sum += 13 * BIT_CYC;          // Start wait, frame, tail
      OP_IRQ:  cost_sum += 2 * BIT_CYC;
      default: cost_sum += 4;                     // One bus access
    endcase
  endtask

  // ------------------------------------------------
  // Bus, serial and interrupt tasks
  // ------------------------------------------------
  task automatic bus_access(input step_t s);
    logic [15:0] exp16;
    logic [15:0] got;
    int          n;
    exp16    = s.lo ? {8'h00, s.exp} : {s.exp, 8'h00};
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = (s.op == OP_WR);
    wb_adr_i = s.adr[2:1];
    wb_sel_i = {s.adr[0], s.lo};
    wb_dat_i = s.lo ? {~s.data, s.data} : {s.data, ~s.data};  // Idle lane inverted
    n = 0;
    do begin
      @(posedge wb_clk_i);
      #1;
      n++;
    end while (!wb_ack_o && (n < 4));
    assert (wb_ack_o) else begin
      errors++;
      $display("No acknowledge for register %0d at %0t ns", s.adr, $time);
    end
    got = wb_dat_o;                               // Valid while ack high
    if (s.op == OP_RD)
      assert (got == exp16) else begin
        errors++;
        $display("Mismatch at %0t ns: wb_dat_o reg %0d expected %h got %h",
                 $time, s.adr, exp16, got);
      end
    // Request still held here, ack must drop for one cycle
    @(posedge wb_clk_i);
    #1;
    assert (!wb_ack_o) else begin
      errors++;
      $display("Acknowledge held a second cycle at %0t ns", $time);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};                      // Stop, data, start
    for (int i = 0; i < 10; i++) begin
      rs232_rx_i = frame[i];
      repeat (BIT_CYC) @(posedge wb_clk_i);
      #1;
    end
  endtask

  task automatic watch_frame(input logic [7:0] exp);
    logic [7:0] got;
    int         n;
    n = 0;
    while (rs232_tx_o && (n < 3 * BIT_CYC)) begin
      @(posedge wb_clk_i);
      #1;
      n++;
    end
    assert (!rs232_tx_o) else begin
      errors++;
      $display("No start bit on rs232_tx_o at %0t ns", $time);
    end
    if (!rs232_tx_o) begin
      repeat (BIT_CYC / 2) @(posedge wb_clk_i);   // Mid start bit
      #1;
      assert (!rs232_tx_o) else begin
        errors++;
        $display("Mismatch at %0t ns: rs232_tx_o start expected 0 got 1", $time);
      end
      for (int i = 0; i < 9; i++) begin
        repeat (BIT_CYC) @(posedge wb_clk_i);
        #1;
        if (i < 8)
          got[i] = rs232_tx_o;                    // LSB first
      end
      assert (rs232_tx_o) else begin
        errors++;
        $display("Mismatch at %0t ns: rs232_tx_o stop expected 1 got 0", $time);
      end
      assert (got == exp) else begin
        errors++;
        $display("Mismatch at %0t ns: rs232_tx_o data expected %h got %h", $time, exp, got);
      end
      repeat (BIT_CYC / 2 + 2) @(posedge wb_clk_i);  // Past end of stop bit
      #1;
    end
  endtask

  task automatic check_irq(input logic level);
    int n;
    n = 0;
    while (level && !wb_tgc_o && (n < 2 * BIT_CYC)) begin
      @(posedge wb_clk_i);
      #1;
      n++;
    end
    assert (wb_tgc_o == level) else begin
      errors++;
      $display("Mismatch at %0t ns: wb_tgc_o expected %b got %b", $time, level, wb_tgc_o);
    end
  endtask

  // ------------------------------------------------
  // Table and main sequence
  // ------------------------------------------------
  initial begin
    logic [7:0] b;
    logic [7:0] b2;
    wb_rst_i   = 1'b1;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = 2'b00;
    wb_sel_i   = 2'b00;
    wb_dat_i   = 16'h0000;
    rs232_rx_i = 1'b1;                            // Line idle
    // Reset defaults and lane steering
    add_step(OP_WR, REG_LCR, 1'b0, 8'h83, 8'h00);
    add_step(OP_RD, REG_THR_RBR, 1'b1, 8'h00, 8'h60);
    add_step(OP_RD, REG_IER, 1'b1, 8'h00, 8'h00);
    add_step(OP_WR, REG_LCR, 1'b0, 8'h03, 8'h00);
    add_step(OP_RD, REG_LCR, 1'b0, 8'h00, 8'h03);
    add_step(OP_RD, REG_IER, 1'b1, 8'h00, 8'h00);
    add_step(OP_RD, REG_IIR, 1'b0, 8'h00, 8'h01);
    add_step(OP_RD, REG_LSR, 1'b0, 8'h00, 8'h60);
    add_step(OP_RD, REG_LCR, 1'b1, 8'h00, 8'h03);
    add_step(OP_IRQ, REG_THR_RBR, 1'b0, 8'h00, 8'h00);
    // Divisor 2
    add_step(OP_WR, REG_LCR, 1'b0, 8'h83, 8'h00);
    add_step(OP_WR, REG_THR_RBR, 1'b1, 8'h02, 8'h00);
    add_step(OP_WR, REG_LCR, 1'b0, 8'h03, 8'h00);
    // Transmit, THRE and TEMT clear mid-frame
    for (int n = 0; n < 2; n++) begin
      b = rand_byte();
      add_step(OP_WR, REG_THR_RBR, 1'b1, b, 8'h00);
      add_step(OP_RD, REG_LSR, 1'b0, 8'h00, 8'h00);
      add_step(OP_TX, REG_THR_RBR, 1'b0, 8'h00, b);
      add_step(OP_RD, REG_LSR, 1'b0, 8'h00, 8'h60);
    end
    // Receive with data available interrupt
    b = rand_byte();
    add_step(OP_WR, REG_IER, 1'b1, 8'h01, 8'h00);
    add_step(OP_SEND, REG_THR_RBR, 1'b0, b, 8'h00);
    add_step(OP_IRQ, REG_THR_RBR, 1'b0, 8'h00, 8'h01);
    add_step(OP_RD, REG_IIR, 1'b0, 8'h00, 8'h04);
    add_step(OP_RD, REG_THR_RBR, 1'b1, 8'h00, b);
    add_step(OP_RD, REG_LSR, 1'b0, 8'h00, 8'h60);
    add_step(OP_IRQ, REG_THR_RBR, 1'b0, 8'h00, 8'h00);
    // Overrun
    b  = rand_byte();
    b2 = rand_byte();
    add_step(OP_SEND, REG_THR_RBR, 1'b0, b, 8'h00);
    add_step(OP_SEND, REG_THR_RBR, 1'b0, b2, 8'h00);
    add_step(OP_RD, REG_LSR, 1'b0, 8'h00, 8'h63);
    add_step(OP_RD, REG_LSR, 1'b0, 8'h00, 8'h61);
    add_step(OP_RD, REG_THR_RBR, 1'b1, 8'h00, b2);
    // Holding register empty interrupt
    b = rand_byte();
    add_step(OP_WR, REG_IER, 1'b1, 8'h02, 8'h00);
    add_step(OP_WR, REG_THR_RBR, 1'b1, b, 8'h00);
    add_step(OP_TX, REG_THR_RBR, 1'b0, 8'h00, b);
    add_step(OP_IRQ, REG_THR_RBR, 1'b0, 8'h00, 8'h01);
    add_step(OP_RD, REG_IIR, 1'b0, 8'h00, 8'h02);
    add_step(OP_RD, REG_IIR, 1'b0, 8'h00, 8'h01);
    add_step(OP_IRQ, REG_THR_RBR, 1'b0, 8'h00, 8'h00);
    cycle_limit = 16 + (cost_sum * 3) / 2;        // Reset plus margin
    repeat (8) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;
    foreach (steps[i]) begin
      case (steps[i].op)
        OP_WR, OP_RD: bus_access(steps[i]);
        OP_SEND:      send_frame(steps[i].data);
        OP_TX:        watch_frame(steps[i].exp);
        default:      check_irq(steps[i].exp[0]);
      endcase
    end
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== files.f ====
design/uart_pkg.sv
design/uart_baud_timer.sv
design/uart_tx_fsm.sv
design/uart_rx.sv
design/uart_regs.sv
design/uart_top.sv
testbench/uart_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UART testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module uart_tb -o uart_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/uart_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
